// File: fb_commit_writer.f
fbw_pkg.sv
fbw_control_fsm.sv
fbw_beat_counter.sv
fbw_burst_addr.sv
fbw_write_data.sv
fb_commit_writer.sv
fb_commit_writer_assert.sv
tb_fb_commit_writer.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run the testbench and scan the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_fb_commit_writer \
    -f fb_commit_writer.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    && ! grep -q "Something failed" sim.log \
    && { cat sim.log; echo "Simulation passed"; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// File: tb_fb_commit_writer.sv
`timescale 1ns/1ps

module tb_fb_commit_writer;

    typedef struct packed {
        logic [fbw_pkg::ADDR_WIDTH - 1 : 0]    base;
        logic [fbw_pkg::FB_SIZE_WIDTH - 1 : 0] size;
        fbw_pkg::mem_resp_t                    resp;
        logic                                  exp_err;
    } test_row_t;

    logic                               aclk = 1'b0;
    logic                               reset = 1'b1;
    logic                               commit = 1'b0;
    fbw_pkg::commit_req_t               commit_req = '0;
    logic                               pix_valid = 1'b0;
    logic [fbw_pkg::DATA_WIDTH - 1 : 0] pix_data = '0;
    logic                               aw_ready = 1'b0;
    logic                               w_ready = 1'b0;
    logic                               b_valid = 1'b0;
    fbw_pkg::mem_resp_t                 b_resp = fbw_pkg::RESP_OKAY;

    logic                               fb_committed;
    logic                               commit_error;
    logic                               pix_ready;
    fbw_pkg::mem_aw_t                   mem_aw;
    logic                               aw_valid;
    fbw_pkg::mem_w_t                    mem_w;
    logic                               w_valid;
    logic                               b_ready;

    test_row_t          rows [7];
    int                 check_count = 0;
    int                 mismatch_count = 0;
    int                 timeout_count = 0;

    // Pixel source state
    logic [31 : 0]      pix_base = '0;
    int                 pix_total = 0;
    int                 pix_sent = 0;
    int                 pix_next = 0;

    // Memory model state
    int                 inject_burst = -1;
    fbw_pkg::mem_resp_t inject_resp = fbw_pkg::RESP_OKAY;
    logic [31 : 0]      burst_addr = '0;
    int                 beat_idx = 0;
    logic               b_pending = 1'b0;
    int                 b_wait = 0;

    logic [31 : 0]      aw_addr_log [$];
    int                 aw_len_log [$];
    logic [31 : 0]      beat_addr_log [$];
    logic [31 : 0]      beat_data_log [$];
    logic [3 : 0]       beat_strb_log [$];
    logic               beat_last_log [$];
    logic [31 : 0]      exp_addr [$];
    int                 exp_len [$];

    fb_commit_writer DUT (
        .aclk(aclk),
        .reset(reset),
        .commit(commit),
        .commit_req(commit_req),
        .fb_committed(fb_committed),
        .commit_error(commit_error),
        .pix_valid(pix_valid),
        .pix_data(pix_data),
        .pix_ready(pix_ready),
        .mem_aw(mem_aw),
        .aw_valid(aw_valid),
        .aw_ready(aw_ready),
        .mem_w(mem_w),
        .w_valid(w_valid),
        .w_ready(w_ready),
        .b_valid(b_valid),
        .b_resp(b_resp),
        .b_ready(b_ready)
    );

    initial
    begin
        forever #5 aclk = ~aclk;
    end

    // Pixel source holds each word until it is taken and inserts random gaps
    always @(posedge aclk)
    begin
        if (reset || fb_committed)
        begin
            pix_valid <= 1'b0;
            pix_sent  <= 0;
        end
        else
        begin
            pix_next = pix_sent + ((pix_valid && pix_ready) ? 1 : 0);
            pix_sent <= pix_next;
            if (!pix_valid || pix_ready)
            begin
                if (pix_next < pix_total && ($urandom % 4) != 0)
                begin
                    pix_valid <= 1'b1;
                    pix_data  <= pix_base + 32'(pix_next);
                end
                else
                begin
                    pix_valid <= 1'b0;
                end
            end
        end
    end

    // Memory model with random ready and response delays; it logs every handshake
    always @(posedge aclk)
    begin
        if (reset)
        begin
            aw_ready  <= 1'b0;
            w_ready   <= 1'b0;
            b_valid   <= 1'b0;
            b_pending = 1'b0;
            b_wait    = 0;
        end
        else
        begin
            aw_ready <= (($urandom % 3) == 0);
            w_ready  <= (($urandom % 4) != 0);
            if (aw_valid && aw_ready)
            begin
                aw_addr_log.push_back(mem_aw.addr);
                aw_len_log.push_back(int'(mem_aw.len));
                burst_addr = mem_aw.addr;
                beat_idx   = 0;
            end
            if (w_valid && w_ready)
            begin
                beat_addr_log.push_back(burst_addr + 32'(4 * beat_idx));
                beat_data_log.push_back(mem_w.data);
                beat_strb_log.push_back(mem_w.strb);
                beat_last_log.push_back(mem_w.last);
                beat_idx++;
                if (mem_w.last)
                begin
                    b_pending = 1'b1;
                    b_wait    = int'($urandom % 4);
                end
            end
            if (b_valid && b_ready)
            begin
                b_valid <= 1'b0;
            end
            else if (!b_valid && b_pending)
            begin
                if (b_wait == 0)
                begin
                    b_valid   <= 1'b1;
                    b_resp    <= (aw_addr_log.size() - 1 == inject_burst) ? inject_resp
                                                                          : fbw_pkg::RESP_OKAY;
                    b_pending = 1'b0;
                end
                else
                begin
                    b_wait--;
                end
            end
        end
    end

    task automatic check_value(input string name, input logic [31 : 0] expected,
                               input logic [31 : 0] actual);
        check_count++;
        if (expected !== actual)
        begin
            mismatch_count++;
            $display("mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    // With no frame in progress every valid, ready and completion output is low
    task automatic check_outputs_idle(input string tag);
        check_value($sformatf("%s aw_valid", tag), 32'd0, 32'(aw_valid));
        check_value($sformatf("%s w_valid", tag), 32'd0, 32'(w_valid));
        check_value($sformatf("%s b_ready", tag), 32'd0, 32'(b_ready));
        check_value($sformatf("%s pix_ready", tag), 32'd0, 32'(pix_ready));
        check_value($sformatf("%s fb_committed", tag), 32'd0, 32'(fb_committed));
        check_value($sformatf("%s commit_error", tag), 32'd0, 32'(commit_error));
    endtask

    // Splits a frame by the burst limit, the frame end and the 4 KiB page end
    task automatic plan_bursts(input logic [31 : 0] base, input int size);
        logic [31 : 0] addr;
        int            left;
        int            room;
        int            len;
        exp_addr.delete();
        exp_len.delete();
        addr = base;
        left = size;
        while (left > 0)
        begin
            room = (fbw_pkg::PAGE_BYTES - int'(addr % 32'(fbw_pkg::PAGE_BYTES))) / 4;
            len  = fbw_pkg::MAX_BURST_LEN;
            if (left < len)
            begin
                len = left;
            end
            if (room < len)
            begin
                len = room;
            end
            exp_addr.push_back(addr);
            exp_len.push_back(len);
            addr = addr + 32'(4 * len);
            left = left - len;
        end
    endtask

    task automatic fill_table();
        rows[0] = '{base: 32'h0000_1000, size: 20'd40, resp: fbw_pkg::RESP_OKAY,   exp_err: 1'b0};
        rows[1] = '{base: 32'h0000_2fe0, size: 20'd20, resp: fbw_pkg::RESP_OKAY,   exp_err: 1'b0};
        rows[2] = '{base: 32'h0001_0ff8, size: 20'd5,  resp: fbw_pkg::RESP_SLVERR, exp_err: 1'b1};
        rows[3] = '{base: 32'h0002_0000, size: 20'd0,  resp: fbw_pkg::RESP_OKAY,   exp_err: 1'b0};
        rows[4] = '{base: 32'h0003_0004, size: 20'd33, resp: fbw_pkg::RESP_DECERR, exp_err: 1'b1};
        rows[5] = '{base: 32'h0004_0fc0, size: 20'd17, resp: fbw_pkg::RESP_EXOKAY, exp_err: 1'b0};
        rows[6] = '{base: 32'h0005_0100, size: 20'd1,  resp: fbw_pkg::RESP_SLVERR, exp_err: 1'b1};
    endtask

    task automatic run_row(input int r, output logic timed_out);
        test_row_t row;
        int        timer;
        logic      seen;
        logic      err_seen;
        logic      exp_last;
        int        k;
        int        pos;
        int        n;
        row       = rows[r];
        timed_out = 1'b0;
        seen      = 1'b0;
        err_seen  = 1'b0;
        timer     = 0;
        plan_bursts(row.base, int'(row.size));
        @(posedge aclk);
        pix_base     <= row.base;
        pix_total    <= int'(row.size);
        inject_burst <= (exp_len.size() == 0) ? -1 : int'($urandom % 32'(exp_len.size()));
        inject_resp  <= row.resp;
        commit_req   <= '{base_addr: row.base, size: row.size};
        commit       <= 1'b1;
        while (!seen && timer < 3000)
        begin
            @(posedge aclk);
            timer++;
            if (fb_committed)
            begin
                seen      = 1'b1;
                err_seen  = commit_error;
                pix_total <= 0;
            end
            if (timer == 1 || timer == 3)
            begin
                commit <= 1'b0;
            end
            else if (timer == 2)
            begin
                check_value($sformatf("row %0d aw_valid after commit", r),
                            32'(row.size != 0), 32'(aw_valid));
                // A second strobe here arrives while the writer is busy
                if (row.size != 0)
                begin
                    commit_req <= '{base_addr: 32'hdead_0000, size: 20'd7};
                    commit     <= 1'b1;
                end
            end
        end
        if (!seen)
        begin
            timeout_count++;
            $display("row %0d: fb_committed did not arrive within 3000 cycles", r);
            timed_out = 1'b1;
        end
        else
        begin
            if (row.size == 0)
            begin
                check_value($sformatf("row %0d size zero latency", r), 32'd2, 32'(timer));
            end
            check_value($sformatf("row %0d commit_error", r), 32'(row.exp_err), 32'(err_seen));
            check_value($sformatf("row %0d burst count", r),
                        32'(exp_len.size()), 32'(aw_addr_log.size()));
            n = (exp_len.size() < aw_addr_log.size()) ? exp_len.size() : aw_addr_log.size();
            for (int i = 0; i < n; i++)
            begin
                check_value($sformatf("row %0d burst %0d address", r, i), exp_addr[i],
                            aw_addr_log[i]);
                check_value($sformatf("row %0d burst %0d length", r, i), 32'(exp_len[i]),
                            32'(aw_len_log[i]));
            end
            check_value($sformatf("row %0d beat count", r), 32'(row.size),
                        32'(beat_data_log.size()));
            k   = 0;
            pos = 0;
            for (int i = 0; i < beat_data_log.size(); i++)
            begin
                exp_last = (k < exp_len.size()) && (pos == exp_len[k] - 1);
                check_value($sformatf("row %0d beat %0d data", r, i), row.base + 32'(i),
                            beat_data_log[i]);
                check_value($sformatf("row %0d beat %0d address", r, i), row.base + 32'(4 * i),
                            beat_addr_log[i]);
                check_value($sformatf("row %0d beat %0d strobes", r, i), 32'hf,
                            32'(beat_strb_log[i]));
                check_value($sformatf("row %0d beat %0d last", r, i), 32'(exp_last),
                            32'(beat_last_log[i]));
                pos++;
                if (k < exp_len.size() && pos == exp_len[k])
                begin
                    k++;
                    pos = 0;
                end
            end
            // The ignored strobe must not start another frame
            repeat (3)
            begin
                @(posedge aclk);
                check_outputs_idle($sformatf("row %0d idle", r));
            end
            aw_addr_log.delete();
            aw_len_log.delete();
            beat_addr_log.delete();
            beat_data_log.delete();
            beat_strb_log.delete();
            beat_last_log.delete();
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, mismatches %0d, timeouts %0d",
                 check_count, mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    endtask

    initial
    begin
        logic timed_out;
        timed_out = 1'b0;
        void'($urandom(32'h9ac0_cc87));
        fill_table();
        repeat (3) @(posedge aclk);
        reset <= 1'b0;
        check_outputs_idle("after reset");
        for (int r = 0; r < $size(rows); r++)
        begin
            run_row(r, timed_out);
            if (timed_out)
            begin
                break;
            end
        end
        finish_run();
    end

endmodule

// File: fb_commit_writer_assert.sv
`timescale 1ns/1ps

module fb_commit_writer_assert
(
    input logic               aclk,
    input logic               reset,
    input fbw_pkg::mem_aw_t   mem_aw,
    input logic               aw_valid,
    input logic               aw_ready,
    input fbw_pkg::mem_w_t    mem_w,
    input logic               w_valid,
    input logic               w_ready,
    input logic               b_valid,
    input logic               b_ready,
    input fbw_pkg::mem_resp_t b_resp,
    input logic               fb_committed
);

    // A stalled channel keeps valid high and its payload unchanged
    aw_hold: assert property (@(posedge aclk) disable iff (reset)
        aw_valid && !aw_ready |=> aw_valid && $stable(mem_aw))
        else $error("address channel changed while stalled");

    w_hold: assert property (@(posedge aclk) disable iff (reset)
        w_valid && !w_ready |=> w_valid && $stable(mem_w))
        else $error("write channel changed while stalled");

    b_hold: assert property (@(posedge aclk) disable iff (reset)
        b_valid && !b_ready |=> b_valid && $stable(b_resp))
        else $error("response channel changed while stalled");

    committed_pulse: assert property (@(posedge aclk) disable iff (reset)
        fb_committed |=> !fb_committed)
        else $error("fb_committed held longer than one cycle");

    // Address and data phases never run together
    no_overlap: assert property (@(posedge aclk) disable iff (reset)
        !(aw_valid && w_valid))
        else $error("aw_valid and w_valid high together");

endmodule

bind fb_commit_writer fb_commit_writer_assert u_assert (
    .aclk(aclk),
    .reset(reset),
    .mem_aw(mem_aw),
    .aw_valid(aw_valid),
    .aw_ready(aw_ready),
    .mem_w(mem_w),
    .w_valid(w_valid),
    .w_ready(w_ready),
    .b_valid(b_valid),
    .b_ready(b_ready),
    .b_resp(b_resp),
    .fb_committed(fb_committed)
);

// File: fb_commit_writer.sv
`timescale 1ns/1ps

module fb_commit_writer
(
    input  logic                               aclk,
    input  logic                               reset,

    // Commit request and completion
    input  logic                               commit,
    input  fbw_pkg::commit_req_t               commit_req,
    output logic                               fb_committed,
    output logic                               commit_error,

    // Pixel stream
    input  logic                               pix_valid,
    input  logic [fbw_pkg::DATA_WIDTH - 1 : 0] pix_data,
    output logic                               pix_ready,

    // Memory write port
    output fbw_pkg::mem_aw_t                   mem_aw,
    output logic                               aw_valid,
    input  logic                               aw_ready,
    output fbw_pkg::mem_w_t                    mem_w,
    output logic                               w_valid,
    input  logic                               w_ready,
    input  logic                               b_valid,
    input  fbw_pkg::mem_resp_t                 b_resp,
    output logic                               b_ready
);
    logic                                    load;
    logic                                    aw_fire;
    logic                                    data_en;
    logic                                    beat_fire;
    logic                                    w_last_fire;
    logic                                    frame_empty;
    logic                                    burst_end;
    logic                                    size_zero;
    logic [fbw_pkg::FB_SIZE_WIDTH - 1 : 0]   words_left;
    logic [fbw_pkg::BURST_LEN_WIDTH - 1 : 0] burst_len;

    // The data phase closes on the handshake of the beat tagged last
    assign w_last_fire = w_valid && w_ready && mem_w.last;

    fbw_control_fsm u_control_fsm (
        .aclk(aclk),
        .reset(reset),
        .commit(commit),
        .size_zero(size_zero),
        .aw_ready(aw_ready),
        .w_last_fire(w_last_fire),
        .b_valid(b_valid),
        .b_resp(b_resp),
        .frame_empty(frame_empty),
        .load(load),
        .aw_valid(aw_valid),
        .aw_fire(aw_fire),
        .data_en(data_en),
        .b_ready(b_ready),
        .fb_committed(fb_committed),
        .commit_error(commit_error)
    );

    fbw_beat_counter u_beat_counter (
        .aclk(aclk),
        .reset(reset),
        .load(load),
        .aw_fire(aw_fire),
        .beat_fire(beat_fire),
        .frame_size(commit_req.size),
        .burst_len(burst_len),
        .words_left(words_left),
        .frame_empty(frame_empty),
        .burst_end(burst_end),
        .size_zero(size_zero)
    );

    fbw_burst_addr u_burst_addr (
        .aclk(aclk),
        .reset(reset),
        .load(load),
        .aw_fire(aw_fire),
        .base_addr(commit_req.base_addr),
        .words_left(words_left),
        .mem_aw(mem_aw),
        .burst_len(burst_len)
    );

    fbw_write_data u_write_data (
        .aclk(aclk),
        .reset(reset),
        .data_en(data_en),
        .burst_end(burst_end),
        .pix_valid(pix_valid),
        .pix_data(pix_data),
        .w_ready(w_ready),
        .pix_ready(pix_ready),
        .w_valid(w_valid),
        .mem_w(mem_w),
        .beat_fire(beat_fire)
    );

endmodule

// File: fbw_write_data.sv
`timescale 1ns/1ps

module fbw_write_data
(
    input  logic                               aclk,
    input  logic                               reset,

    input  logic                               data_en,
    input  logic                               burst_end,

    input  logic                               pix_valid,
    input  logic [fbw_pkg::DATA_WIDTH - 1 : 0] pix_data,
    input  logic                               w_ready,

    output logic                               pix_ready,
    output logic                               w_valid,
    output fbw_pkg::mem_w_t                    mem_w,
    output logic                               beat_fire
);
    logic            full_q;
    fbw_pkg::mem_w_t slot_q;
    logic            draining;

    // The slot frees up in the same cycle its beat leaves, unless that beat
    // closes the burst; then nothing more is taken until the next data phase
    assign draining  = full_q && w_ready && !slot_q.last;
    assign pix_ready = data_en && (!full_q || draining);
    assign beat_fire = pix_valid && pix_ready;

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            full_q <= 1'b0;
        end
        else if (beat_fire)
        begin
            full_q <= 1'b1;
        end
        else if (full_q && w_ready)
        begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (beat_fire)
        begin
            slot_q.data <= pix_data;
            slot_q.strb <= '1;
            slot_q.last <= burst_end;
        end
    end

    assign w_valid = full_q;
    assign mem_w   = slot_q;

endmodule

// File: fbw_burst_addr.sv
`timescale 1ns/1ps

module fbw_burst_addr
(
    input  logic                                    aclk,
    input  logic                                    reset,

    input  logic                                    load,
    input  logic                                    aw_fire,
    input  logic [fbw_pkg::ADDR_WIDTH - 1 : 0]      base_addr,
    input  logic [fbw_pkg::FB_SIZE_WIDTH - 1 : 0]   words_left,

    output fbw_pkg::mem_aw_t                        mem_aw,
    output logic [fbw_pkg::BURST_LEN_WIDTH - 1 : 0] burst_len
);
    logic [fbw_pkg::ADDR_WIDTH - 1 : 0]          addr_q;
    logic [fbw_pkg::PAGE_OFFSET_WIDTH : 0]       room_bytes;
    logic [fbw_pkg::ROOM_WIDTH - 1 : 0]          room_words;
    logic [fbw_pkg::BURST_LEN_WIDTH - 1 : 0]     len;

    // Bytes left up to the next page boundary, at most a full page
    assign room_bytes = (fbw_pkg::PAGE_OFFSET_WIDTH + 1)'(fbw_pkg::PAGE_BYTES)
                      - {1'b0, addr_q[fbw_pkg::PAGE_OFFSET_WIDTH - 1 : 0]};
    assign room_words = room_bytes[fbw_pkg::PAGE_OFFSET_WIDTH : fbw_pkg::WORD_SHIFT];

    // Smallest of the burst limit, the rest of the frame and the page room
    always_comb
    begin
        len = fbw_pkg::BURST_LEN_WIDTH'(fbw_pkg::MAX_BURST_LEN);
        if (words_left < fbw_pkg::FB_SIZE_WIDTH'(len))
        begin
            len = fbw_pkg::BURST_LEN_WIDTH'(words_left);
        end
        if (room_words < fbw_pkg::ROOM_WIDTH'(len))
        begin
            len = fbw_pkg::BURST_LEN_WIDTH'(room_words);
        end
    end

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            addr_q <= '0;
        end
        else if (load)
        begin
            addr_q <= base_addr;
        end
        else if (aw_fire)
        begin
            addr_q <= addr_q + (fbw_pkg::ADDR_WIDTH'(len) << fbw_pkg::WORD_SHIFT);
        end
    end

    assign burst_len   = len;
    assign mem_aw.addr = addr_q;
    assign mem_aw.len  = len;

endmodule

// File: fbw_beat_counter.sv
`timescale 1ns/1ps

module fbw_beat_counter
(
    input  logic                                    aclk,
    input  logic                                    reset,

    input  logic                                    load,
    input  logic                                    aw_fire,
    input  logic                                    beat_fire,
    input  logic [fbw_pkg::FB_SIZE_WIDTH - 1 : 0]   frame_size,
    input  logic [fbw_pkg::BURST_LEN_WIDTH - 1 : 0] burst_len,

    output logic [fbw_pkg::FB_SIZE_WIDTH - 1 : 0]   words_left,
    output logic                                    frame_empty,
    output logic                                    burst_end,
    output logic                                    size_zero
);
    logic [fbw_pkg::FB_SIZE_WIDTH - 1 : 0]   words_q;
    logic [fbw_pkg::BURST_LEN_WIDTH - 1 : 0] beats_q;

    // Words are charged to the frame when the burst address is accepted,
    // so frame_empty already holds during the last burst
    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            words_q <= '0;
        end
        else if (load)
        begin
            words_q <= frame_size;
        end
        else if (aw_fire)
        begin
            words_q <= words_q - fbw_pkg::FB_SIZE_WIDTH'(burst_len);
        end
    end

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            beats_q <= '0;
        end
        else if (load)
        begin
            beats_q <= '0;
        end
        else if (aw_fire)
        begin
            beats_q <= burst_len;
        end
        else if (beat_fire)
        begin
            beats_q <= beats_q - 1'b1;
        end
    end

    assign words_left  = words_q;
    assign frame_empty = (words_q == '0);

    // High while the beat about to be taken is the final one of the burst
    assign burst_end = (beats_q == fbw_pkg::BURST_LEN_WIDTH'(1));

    assign size_zero = (frame_size == '0);

endmodule

// File: fbw_control_fsm.sv
`timescale 1ns/1ps

module fbw_control_fsm
(
    input  logic              aclk,
    input  logic              reset,

    input  logic              commit,
    input  logic              size_zero,
    input  logic              aw_ready,
    input  logic              w_last_fire,
    input  logic              b_valid,
    input  fbw_pkg::mem_resp_t b_resp,
    input  logic              frame_empty,

    output logic              load,
    output logic              aw_valid,
    output logic              aw_fire,
    output logic              data_en,
    output logic              b_ready,
    output logic              fb_committed,
    output logic              commit_error
);
    fbw_pkg::writer_state_t state_q;
    fbw_pkg::writer_state_t state_d;
    logic                   error_q;
    logic                   b_fire;
    logic                   b_is_error;

    // Every handshake strobe is a plain decode of the current state
    assign load         = (state_q == fbw_pkg::WR_IDLE) && commit;
    assign aw_valid     = (state_q == fbw_pkg::WR_ADDR);
    assign aw_fire      = aw_valid && aw_ready;
    assign data_en      = (state_q == fbw_pkg::WR_DATA);
    assign b_ready      = (state_q == fbw_pkg::WR_RESP);
    assign b_fire       = b_ready && b_valid;
    assign fb_committed = (state_q == fbw_pkg::WR_DONE);
    assign commit_error = fb_committed && error_q;

    assign b_is_error = (b_resp == fbw_pkg::RESP_SLVERR) || (b_resp == fbw_pkg::RESP_DECERR);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            fbw_pkg::WR_IDLE:
            begin
                // An empty frame skips the memory side entirely
                if (commit)
                begin
                    state_d = size_zero ? fbw_pkg::WR_DONE : fbw_pkg::WR_ADDR;
                end
            end
            fbw_pkg::WR_ADDR:
            begin
                if (aw_ready)
                begin
                    state_d = fbw_pkg::WR_DATA;
                end
            end
            fbw_pkg::WR_DATA:
            begin
                if (w_last_fire)
                begin
                    state_d = fbw_pkg::WR_RESP;
                end
            end
            fbw_pkg::WR_RESP:
            begin
                if (b_valid)
                begin
                    state_d = frame_empty ? fbw_pkg::WR_DONE : fbw_pkg::WR_ADDR;
                end
            end
            fbw_pkg::WR_DONE:
            begin
                state_d = fbw_pkg::WR_IDLE;
            end
            default:
            begin
                state_d = fbw_pkg::WR_IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            state_q <= fbw_pkg::WR_IDLE;
            error_q <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            // Error flag collects over all bursts of one frame
            if (load)
            begin
                error_q <= 1'b0;
            end
            else if (b_fire && b_is_error)
            begin
                error_q <= 1'b1;
            end
        end
    end

endmodule

// File: fbw_pkg.sv
package fbw_pkg;

    // Memory port widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // Frame size is counted in 32-bit words
    localparam int FB_SIZE_WIDTH = 20;

    // A burst carries 1 to 16 beats, so the beat count needs 5 bits
    localparam int MAX_BURST_LEN = 16;
    localparam int BURST_LEN_WIDTH = 5;

    // No burst may cross this boundary
    localparam int PAGE_BYTES = 4096;

    // Helpers for the boundary arithmetic in the address planner
    localparam int WORD_SHIFT = $clog2(STRB_WIDTH);
    localparam int PAGE_OFFSET_WIDTH = $clog2(PAGE_BYTES);
    localparam int ROOM_WIDTH = PAGE_OFFSET_WIDTH - WORD_SHIFT + 1;

    typedef struct packed {
        logic [ADDR_WIDTH - 1 : 0]    base_addr;
        logic [FB_SIZE_WIDTH - 1 : 0] size;
    } commit_req_t;

    typedef struct packed {
        logic [ADDR_WIDTH - 1 : 0]      addr;
        logic [BURST_LEN_WIDTH - 1 : 0] len;
    } mem_aw_t;

    typedef struct packed {
        logic [DATA_WIDTH - 1 : 0] data;
        logic [STRB_WIDTH - 1 : 0] strb;
        logic                      last;
    } mem_w_t;

    typedef enum logic [1 : 0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } mem_resp_t;

    typedef enum logic [2 : 0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP,
        WR_DONE
    } writer_state_t;

endpackage
